// ==== rtl/vaaddsub.sv ====
// Packed averaging add and subtract unit, combinational, rounding to nearest up
`timescale 1ns/1ps
`include "vec_params.svh"

module vaaddsub (
    input  vec_pkg::instr_type_t instr_type_i,
    input  vec_pkg::sew_t        sew_i,
    input  vec_pkg::bus64_t      data_vs1_i,
    input  vec_pkg::bus64_t      data_vs2_i,
    output vec_pkg::bus64_t      data_vd_o
);

    logic            is_avg_op;
    logic            is_sub;
    logic            is_signed;
    vec_pkg::bus64_t sew_res [4];

    assign is_avg_op = (instr_type_i == vec_pkg::VAADDU) || (instr_type_i == vec_pkg::VAADD)
                    || (instr_type_i == vec_pkg::VASUBU) || (instr_type_i == vec_pkg::VASUB);
    assign is_sub    = (instr_type_i == vec_pkg::VASUBU) || (instr_type_i == vec_pkg::VASUB);
    assign is_signed = (instr_type_i == vec_pkg::VAADD) || (instr_type_i == vec_pkg::VASUB);

    // One lane set per element width, the element width picks one of them
    for (genvar k = 0; k < 4; k++) begin : g_sew
        localparam int W = 8 << k;

        for (genvar e = 0; e < `VEC_WIDTH / W; e++) begin : g_elem
            logic [W:0]   ext_a;
            logic [W:0]   ext_b;
            logic [W:0]   wide;

            // The extra bit copies the sign for signed operations and is zero otherwise
            assign ext_a = {is_signed & data_vs1_i[e*W + W - 1], data_vs1_i[e*W +: W]};
            assign ext_b = {is_signed & data_vs2_i[e*W + W - 1], data_vs2_i[e*W +: W]};

            // vd = (vs2 +/- vs1) >> 1, computed one bit wider so nothing is lost
            assign wide = is_sub ? (ext_b - ext_a) : (ext_b + ext_a);

            // The bit shifted out rounds the halved value up
            assign sew_res[k][e*W +: W] = wide[W:1] + {{(W-1){1'b0}}, wide[0]};
        end
    end

    assign data_vd_o = is_avg_op ? sew_res[sew_i] : '0;

endmodule

// ==== rtl/vec_fxp_unit.sv ====
// Top level of the vector fixed-point subsystem, two units sharing one register-file write port
`timescale 1ns/1ps

module vec_fxp_unit (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // Saturating port
    input  logic                 sat_issue_i,
    input  vec_pkg::instr_type_t sat_op_i,
    input  vec_pkg::sew_t        sat_sew_i,
    input  vec_pkg::bus64_t      sat_vs1_i,
    input  vec_pkg::bus64_t      sat_vs2_i,
    input  vec_pkg::vreg_addr_t  sat_vd_i,
    output logic                 sat_busy_o,
    // Averaging port
    input  logic                 avg_issue_i,
    input  vec_pkg::instr_type_t avg_op_i,
    input  vec_pkg::sew_t        avg_sew_i,
    input  vec_pkg::bus64_t      avg_vs1_i,
    input  vec_pkg::bus64_t      avg_vs2_i,
    input  vec_pkg::vreg_addr_t  avg_vd_i,
    output logic                 avg_busy_o,
    // Debug read and saturation flag
    input  vec_pkg::vreg_addr_t  dbg_addr_i,
    output vec_pkg::bus64_t      dbg_data_o,
    input  logic                 vxsat_clr_i,
    output logic                 vxsat_o
);

    vec_pkg::bus64_t     sat_res;
    logic                sat_ovf;
    vec_pkg::bus64_t     avg_res;
    logic                wr_en;
    vec_pkg::vreg_addr_t wr_addr;
    vec_pkg::bus64_t     wr_data;
    logic                ovf_commit;
    logic                vxsat_q;

    vsaddsub i_vsaddsub (
        .instr_type_i (sat_op_i),
        .sew_i        (sat_sew_i),
        .data_vs1_i   (sat_vs1_i),
        .data_vs2_i   (sat_vs2_i),
        .data_vd_o    (sat_res),
        .sat_ovf_o    (sat_ovf)
    );

    vaaddsub i_vaaddsub (
        .instr_type_i (avg_op_i),
        .sew_i        (avg_sew_i),
        .data_vs1_i   (avg_vs1_i),
        .data_vs2_i   (avg_vs2_i),
        .data_vd_o    (avg_res)
    );

    // Results are captured in the arbiter in the issue cycle
    vwb_arbiter i_vwb_arbiter (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .sat_req_i    (sat_issue_i),
        .sat_addr_i   (sat_vd_i),
        .sat_data_i   (sat_res),
        .sat_ovf_i    (sat_ovf),
        .avg_req_i    (avg_issue_i),
        .avg_addr_i   (avg_vd_i),
        .avg_data_i   (avg_res),
        .sat_busy_o   (sat_busy_o),
        .avg_busy_o   (avg_busy_o),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .ovf_commit_o (ovf_commit)
    );

    vreg_file i_vreg_file (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (dbg_addr_i),
        .rd_data_o (dbg_data_o)
    );

    // Sticky vxsat, a committed overflow wins over a clear in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vxsat_q <= 1'b0;
        end else if (ovf_commit) begin
            vxsat_q <= 1'b1;
        end else if (vxsat_clr_i) begin
            vxsat_q <= 1'b0;
        end
    end

    assign vxsat_o = vxsat_q;

endmodule

// ==== rtl/vec_params.svh ====
// Vector lane sizing constants, included by the RTL and the testbench
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Width of one vector register and of each operand, in bits
`define VEC_WIDTH 64

// Number of architectural vector registers
`define NUM_VREGS 8

// Register index width, enough to address NUM_VREGS entries
`define VREG_AW 3

`endif

// ==== rtl/vec_pkg.sv ====
// Shared vector types for the fixed-point units, referenced by scoped name from every module
`include "vec_params.svh"

package vec_pkg;

    // One vector register worth of packed elements
    typedef logic [`VEC_WIDTH-1:0] bus64_t;

    // Index into the vector register file
    typedef logic [`VREG_AW-1:0] vreg_addr_t;

    // Selected element width
    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    // Fixed-point operations handled by the two units
    // The first four belong to the saturating unit, the last four to the averaging unit
    typedef enum logic [2:0] {
        VSADDU,
        VSADD,
        VSSUBU,
        VSSUB,
        VAADDU,
        VAADD,
        VASUBU,
        VASUB
    } instr_type_t;

endpackage

// ==== rtl/vreg_file.sv ====
// Vector register file with one synchronous write port and one combinational read port
`timescale 1ns/1ps
`include "vec_params.svh"

module vreg_file (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                wr_en_i,
    input  vec_pkg::vreg_addr_t wr_addr_i,
    input  vec_pkg::bus64_t     wr_data_i,
    input  vec_pkg::vreg_addr_t rd_addr_i,
    output vec_pkg::bus64_t     rd_data_o
);

    vec_pkg::bus64_t regs_q [`NUM_VREGS];

    // Registers read zero after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_VREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Read is combinational, a write shows up after its edge
    assign rd_data_o = regs_q[rd_addr_i];

endmodule

// ==== rtl/vsaddsub.sv ====
// Packed saturating add and subtract unit, combinational, with an overflow report for vxsat
`timescale 1ns/1ps
`include "vec_params.svh"

module vsaddsub (
    input  vec_pkg::instr_type_t instr_type_i,
    input  vec_pkg::sew_t        sew_i,
    input  vec_pkg::bus64_t      data_vs1_i,
    input  vec_pkg::bus64_t      data_vs2_i,
    output vec_pkg::bus64_t      data_vd_o,
    output logic                 sat_ovf_o
);

    localparam int NUM_BYTES = `VEC_WIDTH / 8;
    localparam int MASK_W    = $clog2(NUM_BYTES);

    logic                      is_saddu;
    logic                      is_sadd;
    logic                      is_ssubu;
    logic                      is_ssub;
    logic                      is_sat_op;
    logic                      is_sub;
    logic                      is_signed;
    logic [MASK_W-1:0]         elem_mask;
    vec_pkg::bus64_t           data_a;
    logic [NUM_BYTES-1:0]      carry_in;
    logic [NUM_BYTES-1:0]      carry_out;
    logic [NUM_BYTES-1:0][7:0] results;
    logic [NUM_BYTES-1:0]      overflow;
    logic [NUM_BYTES-1:0]      top_byte;

    assign is_saddu  = (instr_type_i == vec_pkg::VSADDU);
    assign is_sadd   = (instr_type_i == vec_pkg::VSADD);
    assign is_ssubu  = (instr_type_i == vec_pkg::VSSUBU);
    assign is_ssub   = (instr_type_i == vec_pkg::VSSUB);
    assign is_sat_op = is_saddu | is_sadd | is_ssubu | is_ssub;
    assign is_sub    = is_ssubu | is_ssub;
    assign is_signed = is_sadd | is_ssub;

    // Low byte-index bits that stay inside one element
    always_comb begin
        case (sew_i)
            vec_pkg::SEW_8:  elem_mask = MASK_W'(0);
            vec_pkg::SEW_16: elem_mask = MASK_W'(1);
            vec_pkg::SEW_32: elem_mask = MASK_W'(3);
            default:         elem_mask = MASK_W'(7);
        endcase
    end

    // Byte adders, vd = vs2 + vs1 or vd = vs2 - vs1 as vs2 + ~vs1 + 1
    always_comb begin
        logic prev_carry;
        prev_carry = 1'b0;
        data_a     = is_sub ? ~data_vs1_i : data_vs1_i;
        for (int i = 0; i < NUM_BYTES; i++) begin
            // A byte inside an element takes the carry of the byte below,
            // the lowest byte of an element takes the subtract carry
            carry_in[i] = ((i & int'(elem_mask)) != 0) ? prev_carry : is_sub;
            {carry_out[i], results[i]} = {1'b0, data_a[i*8 +: 8]}
                                       + {1'b0, data_vs2_i[i*8 +: 8]}
                                       + {8'b0, carry_in[i]};
            prev_carry = carry_out[i];
        end
    end

    // Overflow per byte, only the top byte of each element is meaningful
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            top_byte[i] = ((i & int'(elem_mask)) == int'(elem_mask));
            if (!is_sat_op) begin
                overflow[i] = 1'b0;
            end else if (is_signed) begin
                // Both adder inputs share a sign and the sum has the other sign
                overflow[i] = (data_a[i*8 + 7] == data_vs2_i[i*8 + 7])
                            && (results[i][7] != data_a[i*8 + 7]);
            end else begin
                // Carry out for add, missing carry (a borrow) for subtract
                overflow[i] = carry_out[i] ^ is_sub;
            end
        end
    end

    // Result select, each byte follows the overflow of its element
    always_comb begin
        int   top;
        logic sign;
        for (int i = 0; i < NUM_BYTES; i++) begin
            top  = i | int'(elem_mask);
            sign = data_a[top*8 + 7];
            if (!is_sat_op) begin
                data_vd_o[i*8 +: 8] = 8'h00;
            end else if (!overflow[top]) begin
                data_vd_o[i*8 +: 8] = results[i];
            end else if (!is_signed) begin
                data_vd_o[i*8 +: 8] = is_sub ? 8'h00 : 8'hFF;
            end else if (i == top) begin
                // Positive overflow gives 0111..., negative gives 1000...
                data_vd_o[i*8 +: 8] = {sign, {7{~sign}}};
            end else begin
                data_vd_o[i*8 +: 8] = {8{~sign}};
            end
        end
    end

    assign sat_ovf_o = |(overflow & top_byte);

endmodule

// ==== rtl/vwb_arbiter.sv ====
// Write-back arbiter holding one result per unit and granting the register-file port round-robin
`timescale 1ns/1ps

module vwb_arbiter (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                sat_req_i,
    input  vec_pkg::vreg_addr_t sat_addr_i,
    input  vec_pkg::bus64_t     sat_data_i,
    input  logic                sat_ovf_i,
    input  logic                avg_req_i,
    input  vec_pkg::vreg_addr_t avg_addr_i,
    input  vec_pkg::bus64_t     avg_data_i,
    output logic                sat_busy_o,
    output logic                avg_busy_o,
    output logic                wr_en_o,
    output vec_pkg::vreg_addr_t wr_addr_o,
    output vec_pkg::bus64_t     wr_data_o,
    output logic                ovf_commit_o
);

    typedef enum logic {
        PRIO_SAT,
        PRIO_AVG
    } prio_t;

    prio_t               prio_q;
    logic                sat_valid_q;
    logic                avg_valid_q;
    vec_pkg::vreg_addr_t sat_addr_q;
    vec_pkg::vreg_addr_t avg_addr_q;
    vec_pkg::bus64_t     sat_data_q;
    vec_pkg::bus64_t     avg_data_q;
    logic                sat_ovf_q;
    logic                grant_sat;
    logic                grant_avg;

    // A lone slot always wins, under contention the priority decides
    assign grant_sat = sat_valid_q && (!avg_valid_q || (prio_q == PRIO_SAT));
    assign grant_avg = avg_valid_q && !grant_sat;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sat_valid_q <= 1'b0;
            avg_valid_q <= 1'b0;
            prio_q      <= PRIO_SAT;
        end else begin
            // A slot empties at its write edge, a request fills only an empty slot
            if (grant_sat) begin
                sat_valid_q <= 1'b0;
            end else if (sat_req_i && !sat_valid_q) begin
                sat_valid_q <= 1'b1;
            end
            if (grant_avg) begin
                avg_valid_q <= 1'b0;
            end else if (avg_req_i && !avg_valid_q) begin
                avg_valid_q <= 1'b1;
            end
            // Every grant hands priority to the other unit
            if (grant_sat) begin
                prio_q <= PRIO_AVG;
            end else if (grant_avg) begin
                prio_q <= PRIO_SAT;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sat_req_i && !sat_valid_q) begin
            sat_addr_q <= sat_addr_i;
            sat_data_q <= sat_data_i;
            sat_ovf_q  <= sat_ovf_i;
        end
        if (avg_req_i && !avg_valid_q) begin
            avg_addr_q <= avg_addr_i;
            avg_data_q <= avg_data_i;
        end
    end

    assign sat_busy_o   = sat_valid_q;
    assign avg_busy_o   = avg_valid_q;
    assign wr_en_o      = grant_sat | grant_avg;
    assign wr_addr_o    = grant_sat ? sat_addr_q : avg_addr_q;
    assign wr_data_o    = grant_sat ? sat_data_q : avg_data_q;
    assign ovf_commit_o = grant_sat & sat_ovf_q;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f src.f --top-module vec_fxp_unit_tb -Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vvec_fxp_unit_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Result: FAIL"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "Simulation ended without a pass message"
    exit 1
fi
echo "Result: PASS"
exit 0

// ==== sim/tb_clock_gen.sv ====
// Free-running testbench clock with a 4 ns period, instantiated by the testbench top
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 2;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk_o = ~clk_o;
        end
    end

endmodule

// ==== sim/vec_fxp_tests.txt ====
# op sew vs1 vs2 expected_vd expected_vxsat, all hex, vd = vs2 op vs1
# op 0-3 vsaddu vsadd vssubu vssub, 4-7 vaaddu vaadd vasubu vasub; sew 0-3 = 8/16/32/64 bit
0 0 0102030405060708 1010101010101010 1112131415161718 0
4 0 01FF03800010FF02 02FF048000110102 02FF048000118002 0
1 1 0001FFFF70008000 000200010FFF0001 000300007FFF8001 0
5 1 FFFF7FFF80000003 FFFE7FFF8000FFFF FFFF7FFF80000001 0
2 2 0000000110000000 0000000530000001 0000000420000001 0
6 2 0000000300000001 0000000100000004 FFFFFFFF00000002 0
3 3 0000000000000010 0000000000000005 FFFFFFFFFFFFFFF5 0
7 3 0000000000000005 FFFFFFFFFFFFFFF0 FFFFFFFFFFFFFFF6 0
0 0 F001807F00000010 20028001000000F0 FF03FF80000000FF 1
7 0 01817F0005FF1000 007F800002011003 007F8100FF010002 0
2 1 00100005FFFF0000 000500100000FFFF 0000000B0000FFFF 1
4 2 FFFFFFFF00000001 FFFFFFFF00000002 FFFFFFFF00000002 0
1 2 7FFFFFFF80000000 00000001FFFFFFFF 7FFFFFFF80000000 1
6 1 00010000FFFF0002 0000000500000002 0000000380010000 0
3 0 01FF80100000007F 807F0020000000FF 807F7F1000000080 1
5 3 0000000000000003 0000000000000004 0000000000000004 0
1 3 7FFFFFFFFFFFFFF0 000000000000000F 7FFFFFFFFFFFFFFF 0
0 3 FFFFFFFFFFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFF 1
3 1 0001800000030000 800000000005FFFF 80007FFF0002FFFF 1
2 0 0101010101010101 FFFFFFFFFFFFFFFF FEFEFEFEFEFEFEFE 0
6 3 0000000000000001 0000000000000004 0000000000000002 0
1 0 FEFEFEFEFEFEFEFE 0101010101010101 FFFFFFFFFFFFFFFF 0

// ==== sim/vec_fxp_unit_tb.sv ====
// Testbench for the vector fixed-point subsystem, replays the vectors of sim/vec_fxp_tests.txt
`timescale 1ns/1ps
`include "vec_params.svh"

module vec_fxp_unit_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;

    logic                 clk;
    logic                 reset;
    logic                 sat_issue;
    vec_pkg::instr_type_t sat_op;
    vec_pkg::sew_t        sat_sew;
    vec_pkg::bus64_t      sat_vs1;
    vec_pkg::bus64_t      sat_vs2;
    vec_pkg::vreg_addr_t  sat_vd;
    logic                 sat_busy;
    logic                 avg_issue;
    vec_pkg::instr_type_t avg_op;
    vec_pkg::sew_t        avg_sew;
    vec_pkg::bus64_t      avg_vs1;
    vec_pkg::bus64_t      avg_vs2;
    vec_pkg::vreg_addr_t  avg_vd;
    logic                 avg_busy;
    vec_pkg::vreg_addr_t  dbg_addr;
    vec_pkg::bus64_t      dbg_data;
    logic                 vxsat_clr;
    logic                 vxsat;

    // One entry per line of the vector file
    vec_pkg::instr_type_t t_op[$];
    vec_pkg::sew_t        t_sew[$];
    vec_pkg::bus64_t      t_vs1[$];
    vec_pkg::bus64_t      t_vs2[$];
    vec_pkg::bus64_t      t_exp[$];
    logic                 t_sat[$];
    logic                 loaded = 1'b0;

    tb_clock_gen i_tb_clock_gen (
        .clk_o (clk)
    );

    vec_fxp_unit i_vec_fxp_unit (
        .clk_i       (clk),
        .reset_i     (reset),
        .sat_issue_i (sat_issue),
        .sat_op_i    (sat_op),
        .sat_sew_i   (sat_sew),
        .sat_vs1_i   (sat_vs1),
        .sat_vs2_i   (sat_vs2),
        .sat_vd_i    (sat_vd),
        .sat_busy_o  (sat_busy),
        .avg_issue_i (avg_issue),
        .avg_op_i    (avg_op),
        .avg_sew_i   (avg_sew),
        .avg_vs1_i   (avg_vs1),
        .avg_vs2_i   (avg_vs2),
        .avg_vd_i    (avg_vd),
        .avg_busy_o  (avg_busy),
        .dbg_addr_i  (dbg_addr),
        .dbg_data_o  (dbg_data),
        .vxsat_clr_i (vxsat_clr),
        .vxsat_o     (vxsat)
    );

    task automatic check_vec(string name, vec_pkg::bus64_t expected, vec_pkg::bus64_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Vector result check failed");
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Flag check failed");
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          fields;
        string       line;
        logic [63:0] op_raw;
        logic [63:0] sew_raw;
        logic [63:0] vs1;
        logic [63:0] vs2;
        logic [63:0] exp_val;
        logic [63:0] sat_raw;
        fd = $fopen("sim/vec_fxp_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the test vector file sim/vec_fxp_tests.txt could not be opened");
            $display("SIMULATION FAILED");
            $fatal(1, "Missing test vectors");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Lines starting with a hash describe the columns
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h",
                                     op_raw, sew_raw, vs1, vs2, exp_val, sat_raw);
                    if (fields == 6) begin
                        t_op.push_back(vec_pkg::instr_type_t'(op_raw[2:0]));
                        t_sew.push_back(vec_pkg::sew_t'(sew_raw[1:0]));
                        t_vs1.push_back(vs1);
                        t_vs2.push_back(vs2);
                        t_exp.push_back(exp_val);
                        t_sat.push_back(sat_raw[0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic is_sat_class(vec_pkg::instr_type_t op);
        return op inside {vec_pkg::VSADDU, vec_pkg::VSADD, vec_pkg::VSSUBU, vec_pkg::VSSUB};
    endfunction

    task automatic issue_sat(int idx, vec_pkg::vreg_addr_t vd);
        sat_issue = 1'b1;
        sat_op    = t_op[idx];
        sat_sew   = t_sew[idx];
        sat_vs1   = t_vs1[idx];
        sat_vs2   = t_vs2[idx];
        sat_vd    = vd;
    endtask

    task automatic issue_avg(int idx, vec_pkg::vreg_addr_t vd);
        avg_issue = 1'b1;
        avg_op    = t_op[idx];
        avg_sew   = t_sew[idx];
        avg_vs1   = t_vs1[idx];
        avg_vs2   = t_vs2[idx];
        avg_vd    = vd;
    endtask

    task automatic wait_idle();
        while (sat_busy || avg_busy) begin
            @(negedge clk);
        end
    endtask

    // The debug read is combinational, so sample shortly after the address settles
    task automatic read_check(vec_pkg::vreg_addr_t addr, vec_pkg::bus64_t expected);
        @(negedge clk);
        dbg_addr = addr;
        #1;
        check_vec($sformatf("dbg_data_o[v%0d]", addr), expected, dbg_data);
    endtask

    initial begin
        int                  i;
        int                  sat_line;
        int                  avg_line;
        logic                pair;
        logic                prio_sat;
        logic                exp_sat;
        vec_pkg::vreg_addr_t vd_a;
        vec_pkg::vreg_addr_t vd_b;
        void'($urandom(95847));
        reset     = 1'b1;
        sat_issue = 1'b0;
        sat_op    = vec_pkg::VSADDU;
        sat_sew   = vec_pkg::SEW_8;
        sat_vs1   = '0;
        sat_vs2   = '0;
        sat_vd    = '0;
        avg_issue = 1'b0;
        avg_op    = vec_pkg::VAADDU;
        avg_sew   = vec_pkg::SEW_8;
        avg_vs1   = '0;
        avg_vs2   = '0;
        avg_vd    = '0;
        dbg_addr  = '0;
        vxsat_clr = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_flag("sat_busy_o", 1'b0, sat_busy);
        check_flag("avg_busy_o", 1'b0, avg_busy);
        check_flag("vxsat_o", 1'b0, vxsat);
        for (int r = 0; r < `NUM_VREGS; r++) begin
            read_check(vec_pkg::vreg_addr_t'(r), '0);
        end

        // Port A has priority after reset, every grant passes it on
        prio_sat = 1'b1;
        i = 0;
        while (i < t_op.size()) begin
            pair = (i + 1 < t_op.size()) && (is_sat_class(t_op[i]) != is_sat_class(t_op[i + 1]))
                && ($urandom % 2 == 1);
            @(negedge clk);
            vxsat_clr = 1'b1;
            @(negedge clk);
            vxsat_clr = 1'b0;
            check_flag("vxsat_o", 1'b0, vxsat);
            vd_a = vec_pkg::vreg_addr_t'($urandom % `NUM_VREGS);
            if (pair) begin
                sat_line = is_sat_class(t_op[i]) ? i : i + 1;
                avg_line = is_sat_class(t_op[i]) ? i + 1 : i;
                vd_b = ($urandom % 4 == 0) ? vd_a : vec_pkg::vreg_addr_t'($urandom % `NUM_VREGS);
                issue_sat(sat_line, vd_a);
                issue_avg(avg_line, vd_b);
                @(negedge clk);
                sat_issue = 1'b0;
                avg_issue = 1'b0;
                wait_idle();
                exp_sat = t_sat[sat_line];
                if (vd_a == vd_b) begin
                    // The port without priority writes second and its value remains
                    read_check(vd_a, prio_sat ? t_exp[avg_line] : t_exp[sat_line]);
                end else begin
                    read_check(vd_a, t_exp[sat_line]);
                    read_check(vd_b, t_exp[avg_line]);
                end
                i += 2;
            end else begin
                if (is_sat_class(t_op[i])) begin
                    issue_sat(i, vd_a);
                end else begin
                    issue_avg(i, vd_a);
                end
                @(negedge clk);
                // Keep the strobe up with other data while busy, it must be dropped
                if (is_sat_class(t_op[i])) begin
                    check_flag("sat_busy_o", 1'b1, sat_busy);
                    sat_vs1 = ~sat_vs1;
                end else begin
                    check_flag("avg_busy_o", 1'b1, avg_busy);
                    avg_vs1 = ~avg_vs1;
                end
                @(negedge clk);
                sat_issue = 1'b0;
                avg_issue = 1'b0;
                wait_idle();
                prio_sat = !is_sat_class(t_op[i]);
                exp_sat  = t_sat[i];
                read_check(vd_a, t_exp[i]);
                i += 1;
            end
            check_flag("vxsat_o", exp_sat, vxsat);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog sized from the number of vectors plus the reset time
    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = (longint'(t_op.size()) * 40 + RESET_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("ERROR: timeout, the test run did not finish within %0d ns", limit_ns);
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog timeout");
    end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/vec_pkg.sv
rtl/vsaddsub.sv
rtl/vaaddsub.sv
rtl/vwb_arbiter.sv
rtl/vreg_file.sv
rtl/vec_fxp_unit.sv
sim/tb_clock_gen.sv
sim/vec_fxp_unit_tb.sv
